/* source/pkt_desc_pkg.sv */
package pkt_desc_pkg;

    localparam int DESC_W = 128;

    typedef logic [15:0]       cell_ptr_t;
    typedef logic [10:0]       pkt_len_t;
    typedef logic [5:0]        cell_cnt_t;
    typedef logic [DESC_W-1:0] port_desc_t;

    // upper bit of each field, low bit follows from the type width
    localparam int HEAD_HI = 80;
    localparam int TAIL_HI = 64;
    localparam int LEN_HI  = 48;
    localparam int CNT_HI  = 37;

    // port index width, at least one bit
    function automatic int port_w(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic cell_ptr_t desc_head(port_desc_t d);
        return d[HEAD_HI -: $bits(cell_ptr_t)];
    endfunction

    function automatic cell_ptr_t desc_tail(port_desc_t d);
        return d[TAIL_HI -: $bits(cell_ptr_t)];
    endfunction

    function automatic pkt_len_t desc_len(port_desc_t d);
        return d[LEN_HI -: $bits(pkt_len_t)];
    endfunction

    function automatic cell_cnt_t desc_cells(port_desc_t d);
        return d[CNT_HI -: $bits(cell_cnt_t)];
    endfunction

endpackage

/* source/cell_mem_pkg.sv */
package cell_mem_pkg;

    localparam int BEATS_PER_CELL = 4;

    typedef logic [31:0]                         cell_word_t;
    typedef logic [8:0]                          data_blk_t;
    typedef logic [$clog2(BEATS_PER_CELL)-1:0]   beat_t;
    typedef logic [$bits(data_blk_t)+$bits(beat_t)-1:0] sram_addr_t;

    // next-cell pointer in the upper half of the word
    localparam int NEXT_W  = 16;
    localparam int NEXT_HI = $bits(cell_word_t) - 1;

    // beat that launches the prefetch, and the closing beat of a cell
    localparam beat_t PREFETCH_BEAT = beat_t'(BEATS_PER_CELL - 2);
    localparam beat_t LAST_BEAT     = beat_t'(BEATS_PER_CELL - 1);

    function automatic data_blk_t word_blk(cell_word_t w);
        return w[$bits(data_blk_t)-1:0];
    endfunction

    function automatic logic [NEXT_W-1:0] word_next(cell_word_t w);
        return w[NEXT_HI -: NEXT_W];
    endfunction

    // block index above the beat
    function automatic sram_addr_t make_sram_addr(data_blk_t blk, beat_t beat);
        return {blk, beat};
    endfunction

endpackage

/* source/port_arbiter.sv */
module port_arbiter import pkt_desc_pkg::*; #(
    parameter int  N_PORTS = 4,
    parameter int  HOLDOFF = 100,
    localparam int PW      = port_w(N_PORTS)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [N_PORTS-1:0] pd_ptr_rdy,
    input  logic               take,
    output logic               any_eligible,
    output logic [PW-1:0]      grant_port,
    output logic [N_PORTS-1:0] pd_ptr_ack
);

    localparam int TW = (HOLDOFF > 0) ? $clog2(HOLDOFF + 1) : 1;

    logic [TW-1:0]      timer [N_PORTS];
    logic [N_PORTS-1:0] eligible;
    logic [PW-1:0]      rr_ptr;

    //////////////////////////////////////////////////////////////////////
    // hold-off timers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int p = 0; p < N_PORTS; p++) begin
                timer[p] <= '0;
            end
        end else begin
            for (int p = 0; p < N_PORTS; p++) begin
                if (take && (grant_port == PW'(p))) begin
                    timer[p] <= TW'(HOLDOFF);
                end else if (timer[p] != '0) begin
                    timer[p] <= timer[p] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            eligible[p] = pd_ptr_rdy[p] && (timer[p] == '0);
        end
    end

    assign any_eligible = |eligible;

    //////////////////////////////////////////////////////////////////////
    // round-robin selection
    //////////////////////////////////////////////////////////////////////

    // first eligible port at or above the pointer, wrapping
    always_comb begin
        int   idx;
        logic found;
        grant_port = rr_ptr;
        found      = 1'b0;
        for (int i = 0; i < N_PORTS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= N_PORTS) begin
                idx = idx - N_PORTS;
            end
            if (!found && eligible[idx]) begin
                grant_port = PW'(idx);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr_ptr <= '0;
        end else if (take) begin
            rr_ptr <= (grant_port == PW'(N_PORTS - 1)) ? '0 : grant_port + 1'b1;
        end
    end

    always_comb begin
        pd_ptr_ack = '0;
        if (take) begin
            pd_ptr_ack[grant_port] = 1'b1;
        end
    end

endmodule

/* source/pkt_desc_reg.sv */
module pkt_desc_reg import pkt_desc_pkg::*; #(
    parameter int  N_PORTS = 4,
    localparam int PW      = port_w(N_PORTS)
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [N_PORTS*DESC_W-1:0] pd_ptr_dout,
    input  logic [PW-1:0]             grant_port,
    input  logic                      take,
    input  logic                      cell_done,
    output cell_ptr_t                 head_ptr,
    output cell_ptr_t                 tail_ptr,
    output pkt_len_t                  pkt_len,
    output logic [PW-1:0]             pkt_port,
    output logic                      last_cell
);

    port_desc_t sel_desc;
    cell_cnt_t  cells_left;

    // port 0 sits in the lowest word
    assign sel_desc = pd_ptr_dout[grant_port*DESC_W +: DESC_W];

    always_ff @(posedge clk) begin
        if (take) begin
            head_ptr <= desc_head(sel_desc);
            tail_ptr <= desc_tail(sel_desc);
            pkt_len  <= desc_len(sel_desc);
            pkt_port <= grant_port;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cells_left <= '0;
        end else if (take) begin
            cells_left <= desc_cells(sel_desc);
        end else if (cell_done && (cells_left != '0)) begin
            cells_left <= cells_left - 1'b1;
        end
    end

    // a zero count is read as a single cell
    assign last_cell = (cells_left <= cell_cnt_t'(1));

endmodule

/* source/cell_walker.sv */
module cell_walker import pkt_desc_pkg::*, cell_mem_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  cell_ptr_t  head_ptr,
    input  logic       first_rd,
    input  logic       next_rd,
    input  logic       stream,
    input  cell_word_t cell_mem_dout,
    output logic       cell_mem_rd,
    output cell_ptr_t  cell_mem_addr,
    output sram_addr_t data_sram_addr,
    output logic       prefetch_beat,
    output logic       cell_end
);

    logic      rd_pend;
    data_blk_t blk_q;
    cell_ptr_t next_q;
    beat_t     beat;

    //////////////////////////////////////////////////////////////////////
    // cell memory side
    //////////////////////////////////////////////////////////////////////

    assign cell_mem_rd   = first_rd || next_rd;
    assign cell_mem_addr = first_rd ? head_ptr : next_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= cell_mem_rd;
        end
    end

    // word valid one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            blk_q  <= word_blk(cell_mem_dout);
            next_q <= word_next(cell_mem_dout);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // beat sequencing
    //////////////////////////////////////////////////////////////////////

    // wraps to 0 after the last beat of each cell
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat <= '0;
        end else if (stream) begin
            beat <= beat + 1'b1;
        end
    end

    assign prefetch_beat  = stream && (beat == PREFETCH_BEAT);
    assign cell_end       = stream && (beat == LAST_BEAT);
    assign data_sram_addr = make_sram_addr(blk_q, beat);

endmodule

/* source/read_ctrl.sv */
module read_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic any_eligible,
    input  logic last_cell,
    input  logic prefetch_beat,
    input  logic cell_end,
    output logic take,
    output logic first_rd,
    output logic next_rd,
    output logic stream,
    output logic cell_done,
    output logic fq_wr,
    output logic pkt_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_stream,
        st_release
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (any_eligible) begin
                    state_nxt = st_fetch;
                end
            end
            // head cell word is back one cycle after the read
            st_fetch: state_nxt = st_wait;
            st_wait:  state_nxt = st_stream;
            st_stream: begin
                if (cell_end && last_cell) begin
                    state_nxt = st_release;
                end
            end
            st_release: state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    assign take     = (state == st_idle) && any_eligible;
    assign first_rd = (state == st_fetch);
    assign stream   = (state == st_stream);

    // no prefetch past the tail cell
    assign next_rd   = stream && prefetch_beat && !last_cell;
    assign cell_done = stream && cell_end;

    // release returns the chain and reports the packet together
    assign fq_wr    = (state == st_release);
    assign pkt_done = (state == st_release);

endmodule

/* source/cell_reader_top.sv */
module cell_reader_top import pkt_desc_pkg::*, cell_mem_pkg::*; #(
    parameter int  N_PORTS = 4,
    parameter int  HOLDOFF = 100,
    localparam int PW      = port_w(N_PORTS)
) (
    input  logic                      clk,
    input  logic                      rstn,

    input  logic [N_PORTS-1:0]        pd_ptr_rdy,
    input  logic [N_PORTS*DESC_W-1:0] pd_ptr_dout,
    output logic [N_PORTS-1:0]        pd_ptr_ack,

    output logic                      cell_mem_rd,
    output cell_ptr_t                 cell_mem_addr,
    input  cell_word_t                cell_mem_dout,

    output sram_addr_t                data_sram_addr,
    output logic                      data_valid,

    output logic                      fq_wr,
    output cell_ptr_t                 fq_head,
    output cell_ptr_t                 fq_tail,

    output logic                      pkt_done,
    output logic [PW-1:0]             pkt_port,
    output pkt_len_t                  pkt_len
);

    logic          any_eligible;
    logic [PW-1:0] grant_port;
    logic          take;
    cell_ptr_t     head_ptr;
    logic          last_cell;
    logic          first_rd;
    logic          next_rd;
    logic          stream;
    logic          cell_done;
    logic          prefetch_beat;
    logic          cell_end;

    assign fq_head    = head_ptr;
    assign data_valid = stream;

    //////////////////////////////////////////////////////////////////////
    // queue selection and descriptor capture
    //////////////////////////////////////////////////////////////////////

    port_arbiter #(
        .N_PORTS (N_PORTS),
        .HOLDOFF (HOLDOFF)
    ) u_port_arbiter (
        .clk          (clk),
        .rstn         (rstn),
        .pd_ptr_rdy   (pd_ptr_rdy),
        .take         (take),
        .any_eligible (any_eligible),
        .grant_port   (grant_port),
        .pd_ptr_ack   (pd_ptr_ack)
    );

    pkt_desc_reg #(
        .N_PORTS (N_PORTS)
    ) u_pkt_desc_reg (
        .clk         (clk),
        .rstn        (rstn),
        .pd_ptr_dout (pd_ptr_dout),
        .grant_port  (grant_port),
        .take        (take),
        .cell_done   (cell_done),
        .head_ptr    (head_ptr),
        .tail_ptr    (fq_tail),
        .pkt_len     (pkt_len),
        .pkt_port    (pkt_port),
        .last_cell   (last_cell)
    );

    //////////////////////////////////////////////////////////////////////
    // chain walk and sequencing
    //////////////////////////////////////////////////////////////////////

    cell_walker u_cell_walker (
        .clk            (clk),
        .rstn           (rstn),
        .head_ptr       (head_ptr),
        .first_rd       (first_rd),
        .next_rd        (next_rd),
        .stream         (stream),
        .cell_mem_dout  (cell_mem_dout),
        .cell_mem_rd    (cell_mem_rd),
        .cell_mem_addr  (cell_mem_addr),
        .data_sram_addr (data_sram_addr),
        .prefetch_beat  (prefetch_beat),
        .cell_end       (cell_end)
    );

    read_ctrl u_read_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .any_eligible  (any_eligible),
        .last_cell     (last_cell),
        .prefetch_beat (prefetch_beat),
        .cell_end      (cell_end),
        .take          (take),
        .first_rd      (first_rd),
        .next_rd       (next_rd),
        .stream        (stream),
        .cell_done     (cell_done),
        .fq_wr         (fq_wr),
        .pkt_done      (pkt_done)
    );

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after a rising edge, like the other stimulus
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

/* tests/cell_reader_properties.sv */
module cell_reader_properties #(
    parameter int N_PORTS = 4
) (
    input logic               clk,
    input logic               rstn,
    input logic [N_PORTS-1:0] ack,
    input logic               stream,
    input logic               cell_end,
    input logic               last_cell,
    input logic               fq_wr,
    input logic               pkt_done
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    ack_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(ack))
    else begin
        $error("pd_ptr_ack has more than one bit set: %b", ack);
        fail_cnt++;
    end

    done_with_release: assert property (@(posedge clk) disable iff (!rstn) pkt_done == fq_wr)
    else begin
        $error("pkt_done and fq_wr differ");
        fail_cnt++;
    end

    // no hole in the beat stream of one packet
    stream_steady: assert property (@(posedge clk) disable iff (!rstn)
        stream && !(cell_end && last_cell) |=> stream)
    else begin
        $error("data_valid dropped inside a packet");
        fail_cnt++;
    end

endmodule

bind read_ctrl cell_reader_properties u_ctrl_props (
    .clk       (clk),
    .rstn      (rstn),
    .ack       ('0),
    .stream    (stream),
    .cell_end  (cell_end),
    .last_cell (last_cell),
    .fq_wr     (fq_wr),
    .pkt_done  (pkt_done)
);

bind port_arbiter cell_reader_properties #(.N_PORTS(N_PORTS)) u_arb_props (
    .clk       (clk),
    .rstn      (rstn),
    .ack       (pd_ptr_ack),
    .stream    (1'b0),
    .cell_end  (1'b0),
    .last_cell (1'b0),
    .fq_wr     (1'b0),
    .pkt_done  (1'b0)
);

/* tests/tb_cell_reader.sv */
module tb_cell_reader import pkt_desc_pkg::*, cell_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_PORTS = 4;
    localparam int HOLDOFF = 20;
    localparam int MAX_PKT = 64;
    localparam int N_PKTS  = 52;
    localparam int TIMEOUT_CYCLES = 2 * N_PKTS * (4 * 8 + 4 + HOLDOFF);

    logic                      clk;
    logic                      rstn;
    logic [N_PORTS-1:0]        pd_ptr_rdy;
    logic [N_PORTS*DESC_W-1:0] pd_ptr_dout;
    logic [N_PORTS-1:0]        pd_ptr_ack;
    logic                      cell_mem_rd;
    cell_ptr_t                 cell_mem_addr;
    cell_word_t                cell_mem_dout;
    sram_addr_t                data_sram_addr;
    logic                      data_valid;
    logic                      fq_wr;
    cell_ptr_t                 fq_head;
    cell_ptr_t                 fq_tail;
    logic                      pkt_done;
    logic [1:0]                pkt_port;
    pkt_len_t                  pkt_len;

    cell_word_t cell_mem [0:65535];
    logic       mem_pend;
    cell_ptr_t  mem_addr;

    // packet table the queue models present in arrival order
    port_desc_t pk_desc    [MAX_PKT];
    int         pk_port    [MAX_PKT];
    int         pk_cells   [MAX_PKT];
    cell_ptr_t  pk_head    [MAX_PKT];
    cell_ptr_t  pk_tail    [MAX_PKT];
    pkt_len_t   pk_len     [MAX_PKT];
    bit         pk_pending [MAX_PKT];
    int         shown      [N_PORTS];
    int         last_grant [N_PORTS];
    int         n_pkts;
    int         n_done;
    int         alloc_ptr;
    integer     seed;

    int cyc;
    bit active;
    int t;
    int cur;
    int rr_ref;

    tb_clock u_tb_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    cell_reader_top #(
        .N_PORTS (N_PORTS),
        .HOLDOFF (HOLDOFF)
    ) DUT (
        .clk            (clk),
        .rstn           (rstn),
        .pd_ptr_rdy     (pd_ptr_rdy),
        .pd_ptr_dout    (pd_ptr_dout),
        .pd_ptr_ack     (pd_ptr_ack),
        .cell_mem_rd    (cell_mem_rd),
        .cell_mem_addr  (cell_mem_addr),
        .cell_mem_dout  (cell_mem_dout),
        .data_sram_addr (data_sram_addr),
        .data_valid     (data_valid),
        .fq_wr          (fq_wr),
        .fq_head        (fq_head),
        .fq_tail        (fq_tail),
        .pkt_done       (pkt_done),
        .pkt_port       (pkt_port),
        .pkt_len        (pkt_len)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model and checking
    //////////////////////////////////////////////////////////////////////

    function automatic cell_ptr_t chain_ptr(cell_ptr_t head, int steps);
        cell_ptr_t p;
        p = head;
        for (int i = 0; i < steps; i++) begin
            p = cell_mem[p][31:16];
        end
        return p;
    endfunction

    // beat k takes the block of cell k/4 with beat k%4 below it
    function automatic sram_addr_t expected_beat_addr(cell_ptr_t head, int k);
        cell_word_t w;
        w = cell_mem[chain_ptr(head, k / 4)];
        return {w[8:0], 2'(k % 4)};
    endfunction

    function automatic int port_head(int p);
        int idx;
        idx = -1;
        for (int i = 0; i < n_pkts; i++) begin
            if (idx < 0 && pk_pending[i] && pk_port[i] == p) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic create_packet(input int port, input int cells);
        cell_ptr_t  ptrs [8];
        cell_ptr_t  next;
        port_desc_t d;
        pkt_len_t   len;
        for (int i = 0; i < cells; i++) begin
            alloc_ptr = alloc_ptr + 1 + ($random(seed) & 15);
            ptrs[i] = cell_ptr_t'(alloc_ptr);
        end
        for (int i = 0; i < cells; i++) begin
            next = (i < cells - 1) ? ptrs[i + 1] : cell_ptr_t'($random(seed));
            cell_mem[ptrs[i]] = {next, 7'($random(seed)), 9'($random(seed))};
        end
        len = pkt_len_t'(cells * 64 - ($random(seed) & 63));
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        d[80 -: 16] = ptrs[0];
        d[64 -: 16] = ptrs[cells - 1];
        d[48 -: 11] = len;
        d[37 -: 6]  = 6'(cells);
        pk_desc[n_pkts]    = d;
        pk_port[n_pkts]    = port;
        pk_cells[n_pkts]   = cells;
        pk_head[n_pkts]    = ptrs[0];
        pk_tail[n_pkts]    = ptrs[cells - 1];
        pk_len[n_pkts]     = len;
        pk_pending[n_pkts] = 1'b1;
        n_pkts = n_pkts + 1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // queue and memory models
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        mem_pend = cell_mem_rd;
        mem_addr = cell_mem_addr;
    end

    always @(posedge clk) begin
        int idx;
        #1;
        for (int p = 0; p < N_PORTS; p++) begin
            idx = port_head(p);
            shown[p] = idx;
            pd_ptr_rdy[p] = (idx >= 0);
            pd_ptr_dout[p*DESC_W +: DESC_W] = (idx >= 0) ? pk_desc[idx] : '0;
        end
        // word for the read seen in the previous cycle
        if (mem_pend) begin
            cell_mem_dout = cell_mem[mem_addr];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare process sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        int         n;
        int         k;
        int         p;
        int         exp_p;
        logic [3:0] exp_ack;
        bit         exp_valid;
        bit         exp_rd;
        bit         exp_rel;
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout: packets still outstanding after %0d cycles", cyc);
            stop_on_failure();
        end
        check_value("assertion failures",
                    DUT.u_read_ctrl.u_ctrl_props.fail_cnt +
                    DUT.u_port_arbiter.u_arb_props.fail_cnt, 0);
        if (active) begin
            t = t + 1;
            n = pk_cells[cur];
            k = t - 3;
            exp_valid = (t >= 3) && (t <= 2 + 4 * n);
            exp_rel   = (t == 3 + 4 * n);
            exp_rd    = (t == 1) || (exp_valid && (k % 4 == 2) && (k / 4 < n - 1));
            check_value("pd_ptr_ack", pd_ptr_ack, 0);
            check_value("data_valid", data_valid, exp_valid);
            check_value("cell_mem_rd", cell_mem_rd, exp_rd);
            check_value("fq_wr", fq_wr, exp_rel);
            check_value("pkt_done", pkt_done, exp_rel);
            if (t == 1) begin
                check_value("cell_mem_addr", cell_mem_addr, pk_head[cur]);
            end else if (exp_rd) begin
                check_value("cell_mem_addr", cell_mem_addr,
                            chain_ptr(pk_head[cur], k / 4 + 1));
            end
            if (exp_valid) begin
                check_value("data_sram_addr", data_sram_addr,
                            expected_beat_addr(pk_head[cur], k));
            end
            if (exp_rel) begin
                check_value("fq_head", fq_head, pk_head[cur]);
                check_value("fq_tail", fq_tail, pk_tail[cur]);
                check_value("pkt_port", pkt_port, pk_port[cur]);
                check_value("pkt_len", pkt_len, pk_len[cur]);
                active = 1'b0;
                n_done = n_done + 1;
            end
        end else if (rstn) begin
            check_value("data_valid", data_valid, 0);
            check_value("cell_mem_rd", cell_mem_rd, 0);
            check_value("fq_wr", fq_wr, 0);
            check_value("pkt_done", pkt_done, 0);
            if (pd_ptr_ack != '0) begin
                // hold-off spacing measured on the acked port
                for (int i = 0; i < N_PORTS; i++) begin
                    if (pd_ptr_ack[i] && last_grant[i] >= 0) begin
                        check_value("pd_ptr_ack spacing",
                                    (cyc - last_grant[i]) >= HOLDOFF + 1, 1);
                    end
                end
                // first ready port out of hold-off searching upward from the pointer
                exp_p = -1;
                for (int i = 0; i < N_PORTS; i++) begin
                    p = (rr_ref + i) % N_PORTS;
                    if (exp_p < 0 && pd_ptr_rdy[p] &&
                        (last_grant[p] < 0 || cyc - last_grant[p] >= HOLDOFF + 1)) begin
                        exp_p = p;
                    end
                end
                exp_ack = (exp_p >= 0) ? 4'(1 << exp_p) : 4'b0;
                check_value("pd_ptr_ack", pd_ptr_ack, exp_ack);
                last_grant[exp_p] = cyc;
                rr_ref = (exp_p + 1) % N_PORTS;
                cur = shown[exp_p];
                pk_pending[cur] = 1'b0;
                active = 1'b1;
                t = 0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int port;
        int cells;
        seed          = 32'h457e6130;
        pd_ptr_rdy    = '0;
        pd_ptr_dout   = '0;
        cell_mem_dout = '0;
        mem_pend      = 1'b0;
        mem_addr      = '0;
        n_pkts        = 0;
        n_done        = 0;
        alloc_ptr     = 16'h0100;
        cyc           = 0;
        active        = 1'b0;
        t             = 0;
        cur           = 0;
        rr_ref        = 0;
        for (int p = 0; p < N_PORTS; p++) begin
            shown[p]      = -1;
            last_grant[p] = -1;
        end
        for (int a = 0; a < 65536; a++) begin
            cell_mem[a] = {16'(a) ^ 16'h3c5a, 7'h0, 9'(a) ^ 9'(a >> 7)};
        end

        // quiet period with all outputs low
        wait (rstn);
        repeat (5) @(negedge clk);

        // one packet on port 2
        create_packet(2, 5);
        wait (n_done == n_pkts);
        @(negedge clk);

        // all queues busy so grants rotate
        for (int i = 0; i < 8; i++) begin
            cells = 1 + ($random(seed) & 1);
            create_packet(i % N_PORTS, cells);
        end
        wait (n_done == n_pkts);
        @(negedge clk);

        // a single queue paced by its hold-off
        for (int i = 0; i < 3; i++) begin
            create_packet(1, 1);
        end
        wait (n_done == n_pkts);
        @(negedge clk);

        for (int i = 0; i < 40; i++) begin
            port  = $random(seed) & 3;
            cells = 1 + ($random(seed) & 7);
            create_packet(port, cells);
        end
        wait (n_done == n_pkts);
        repeat (5) @(negedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb.f */
source/pkt_desc_pkg.sv
source/cell_mem_pkg.sv
source/port_arbiter.sv
source/pkt_desc_reg.sv
source/cell_walker.sv
source/read_ctrl.sv
source/cell_reader_top.sv
tests/tb_clock.sv
tests/cell_reader_properties.sv
tests/tb_cell_reader.sv
